/* source/bridge_pkg.sv */
`default_nettype none

package bridge_pkg;

  // bus and ring widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int MSG_W  = 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // ring index layout: top bit active flag, rest is position count
  localparam int CPU_ACTIVE_BIT = DATA_W - 1;

  // thread header sits in front of the code and data areas
  localparam addr_t THREAD_HEADER_SPACE = 16;

  // post-reset step counter
  localparam int STEP_W = 3;
  localparam logic [STEP_W-1:0] RESET_LAST_STEP = 3'd5;

  // messages put on the ring
  typedef enum logic [MSG_W-1:0] {
    MSG_NONE  = 8'd0,
    MSG_RESET = 8'd1,
    MSG_START = 8'd2,
    MSG_END   = 8'd3
  } cpu_msg_e;

  // core state, as seen from the bridge
  typedef enum logic [5:0] {
    WAIT_FOR_START, START_BEGIN,
    READ_COND, READ_COND_P, READ_SRC1, READ_SRC1_P, READ_SRC0, READ_SRC0_P, READ_DST,
    START_READ_CMD, START_READ_CMD_P,
    WRITE_REG_IP, WRITE_DST, WRITE_DST_P, WRITE_SRC1, WRITE_SRC0, WRITE_COND,
    ALU_BEGIN, FINISH_BEGIN, FINISH_END, IDLE
  } cpu_state_e;

  // operand reads and command fetch
  function automatic logic is_read_state(cpu_state_e s);
    case (s)
      READ_COND, READ_COND_P, READ_SRC1, READ_SRC1_P,
      READ_SRC0, READ_SRC0_P, READ_DST,
      START_READ_CMD, START_READ_CMD_P: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // result and register writes
  function automatic logic is_write_state(cpu_state_e s);
    case (s)
      WRITE_REG_IP, WRITE_DST, WRITE_DST_P,
      WRITE_SRC1, WRITE_SRC0, WRITE_COND: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

`default_nettype wire

/* source/index_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface index_if;
  import bridge_pkg::*;

  // own ring position and match against the ring index
  data_t own_index;
  logic  index_match;

  // sequencer controls
  logic  load_index;
  logic  seq_done;

  // finish of the running thread, restarts the sequence
  logic  thread_end;

  modport tracker (
    input  load_index, seq_done, thread_end,
    output own_index, index_match
  );

  modport sequencer (
    output load_index, seq_done,
    input  thread_end
  );

  modport arbiter (
    input  seq_done, index_match,
    output thread_end
  );

endinterface

`default_nettype wire

/* source/reset_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module reset_sequencer (
  input  logic                   clk,
  input  logic                   ext_rst_b,
  input  bridge_pkg::cpu_state_e state,
  index_if.sequencer             seq,
  output logic                   rst,
  output logic                   ext_rst_e,
  output logic                   reset_msg
);
  import bridge_pkg::*;

  logic [STEP_W-1:0] step;
  logic              load_step;

  // step 2 takes the ring index and announces the reset
  assign load_step     = (step == 3'd2);
  assign seq.load_index = load_step;
  assign reset_msg     = load_step;

  // done from the dispatcher step on
  // arbiter itself waits one more cycle
  assign seq.seq_done = (step >= RESET_LAST_STEP - 3'd1);

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      step      <= '0;
      rst       <= 1'b0;
      ext_rst_e <= 1'b0;
    end else begin
      // core reset pulse out of step 3
      rst <= (step == 3'd3);
      // external side only on a cold start, not after a finished thread
      ext_rst_e <= (step == 3'd3) && (state != FINISH_END);

      if (seq.thread_end) begin
        // thread finished, run the sequence again
        step <= '0;
      end else begin
        case (step)
          3'd0: step <= 3'd1;
          // core already parked at FINISH_END keeps its index
          3'd1: step <= (state == FINISH_END) ? 3'd3 : 3'd2;
          // hold at the last step
          RESET_LAST_STEP: step <= step;
          default: step <= step + 1'b1;
        endcase
      end
    end
  end

  // core reset is a single-cycle strobe
  a_rst_single_pulse : assert property (
    @(posedge clk) disable iff (ext_rst_b)
    rst |=> !rst
  );

endmodule

`default_nettype wire

/* source/cpu_index_tracker.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_index_tracker (
  input  logic                   clk,
  input  logic                   ext_rst_b,
  input  bridge_pkg::cpu_state_e state,
  input  bridge_pkg::data_t      ext_cpu_index,
  input  bridge_pkg::cpu_msg_e   ext_cpu_msg_in,
  index_if.tracker               trk
);
  import bridge_pkg::*;

  logic                      own_active;
  logic                      other_active;
  logic                      other_below;
  logic [CPU_ACTIVE_BIT-1:0] own_count;
  logic [CPU_ACTIVE_BIT-1:0] other_count;

  assign own_active   = trk.own_index[CPU_ACTIVE_BIT];
  assign other_active = ext_cpu_index[CPU_ACTIVE_BIT];
  assign own_count    = trk.own_index[CPU_ACTIVE_BIT-1:0];
  assign other_count  = ext_cpu_index[CPU_ACTIVE_BIT-1:0];
  assign other_below  = (other_count < own_count);

  // token addressed to this cpu
  assign trk.index_match = (ext_cpu_index == trk.own_index);

  always_ff @(posedge clk) begin
    // index survives the external reset
    if (!ext_rst_b) begin
      if (trk.load_index) begin
        // position handed over by the ring during the sequence
        trk.own_index <= ext_cpu_index;
      end else if (trk.thread_end) begin
        // leaves the ring as inactive slot 0
        trk.own_index <= '0;
      end else if (trk.seq_done) begin
        if (state == START_BEGIN) begin
          trk.own_index[CPU_ACTIVE_BIT] <= 1'b1;
        end else if (!trk.index_match) begin
          if (other_active) begin
            // an active cpu ahead of us finished, move one slot up
            if (ext_cpu_msg_in == MSG_END && own_active && other_below) begin
              trk.own_index[CPU_ACTIVE_BIT-1:0] <= own_count - 1'b1;
            end
          end else if (ext_cpu_msg_in == MSG_START) begin
            // new thread joins the active group
            // active cpus shift back, idle ones shift forward
            if (own_active) begin
              trk.own_index[CPU_ACTIVE_BIT-1:0] <= own_count + 1'b1;
            end else begin
              trk.own_index[CPU_ACTIVE_BIT-1:0] <= own_count - 1'b1;
            end
          end
        end
      end
    end
  end

  // load happens only early in the sequence, thread end only after it
  a_load_vs_end : assert property (
    @(posedge clk) disable iff (ext_rst_b)
    !(trk.load_index && trk.thread_end)
  );

endmodule

`default_nettype wire

/* source/ring_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module ring_arbiter (
  input  logic                   clk,
  input  logic                   ext_rst_b,
  input  bridge_pkg::cpu_state_e state,
  input  logic                   read_q,
  input  logic                   write_q,
  input  bridge_pkg::addr_t      addr_in,
  input  bridge_pkg::data_t      data_in,
  input  logic                   ext_next_cpu_q,
  input  logic                   ext_bus_busy,
  input  logic                   reset_msg,
  index_if.arbiter               arb,
  output logic                   disp_online,
  output logic                   next_state,
  output logic                   ext_next_cpu_e,
  output logic                   ext_dispatcher_q,
  output bridge_pkg::cpu_msg_e   ext_cpu_msg,
  output bridge_pkg::addr_t      base_addr,
  output bridge_pkg::addr_t      base_addr_data,
  output logic                   ext_read_q,
  output logic                   ext_write_q
);
  import bridge_pkg::*;

  logic  grant;
  logic  rd_class;
  logic  wr_class;
  logic  done_q;
  logic  live;
  addr_t addr_hdr;
  data_t data_hdr;

  // token is here and it carries our index
  assign grant    = ext_next_cpu_q && arb.index_match;
  assign rd_class = is_read_state(state);
  assign wr_class = is_write_state(state);

  // first done cycle belongs to the dispatcher step
  assign live = arb.seq_done && done_q;

  // thread base skips the header
  assign addr_hdr = addr_in + THREAD_HEADER_SPACE;
  assign data_hdr = data_in + THREAD_HEADER_SPACE;

  // finished thread hands back to the sequencer in the same cycle
  assign arb.thread_end = live && !ext_bus_busy && !grant && (state == FINISH_END);

  // core requests pass only while we own the bus
  assign ext_read_q  = rd_class && disp_online && read_q;
  assign ext_write_q = wr_class && disp_online && write_q;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      disp_online      <= 1'b0;
      next_state       <= 1'b0;
      ext_next_cpu_e   <= 1'b0;
      ext_dispatcher_q <= 1'b0;
      ext_cpu_msg      <= MSG_NONE;
      base_addr        <= '0;
      base_addr_data   <= '0;
      done_q           <= 1'b0;
    end else begin
      // single-cycle strobes
      next_state  <= 1'b0;
      ext_cpu_msg <= MSG_NONE;
      done_q      <= arb.seq_done;

      if (!arb.seq_done) begin
        // sequence running, drop ownership
        disp_online      <= 1'b0;
        ext_next_cpu_e   <= 1'b0;
        ext_dispatcher_q <= 1'b0;
        if (reset_msg) begin
          ext_cpu_msg <= MSG_RESET;
        end
      end else if (!done_q) begin
        // dispatcher request at the end of the sequence
        ext_dispatcher_q <= 1'b1;
      end else if (!ext_bus_busy) begin
        // pass the token on once the request is served
        if (disp_online) begin
          if (read_q || write_q) begin
            ext_next_cpu_e <= 1'b1;
          end else if (ext_next_cpu_e) begin
            ext_next_cpu_e <= 1'b0;
            disp_online    <= 1'b0;
          end
        end

        if (grant) begin
          disp_online <= 1'b1;
          case (state)
            WAIT_FOR_START: begin
              ext_cpu_msg <= MSG_START;
              base_addr   <= addr_hdr;
              // no data pointer, data follows the code
              base_addr_data <= (data_in == '0) ? addr_hdr : data_hdr;
              ext_next_cpu_e <= 1'b1;
              next_state     <= 1'b1;
            end
            FINISH_BEGIN: begin
              ext_cpu_msg    <= MSG_END;
              ext_next_cpu_e <= 1'b1;
              next_state     <= 1'b1;
            end
            default: begin
              if (rd_class || wr_class) begin
                ext_dispatcher_q <= 1'b1;
              end
            end
          endcase
        end else if (rd_class || wr_class) begin
          ext_dispatcher_q <= 1'b1;
        end else if (state != FINISH_END) begin
          ext_dispatcher_q <= 1'b0;
        end
      end
    end
  end

  // read and write classes never overlap
  a_rw_exclusive : assert property (
    @(posedge clk) disable iff (ext_rst_b)
    !(ext_read_q && ext_write_q)
  );

endmodule

`default_nettype wire

/* source/cpu_bus_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_bus_bridge (
  input  logic                   clk,
  input  logic                   ext_rst_b,
  input  bridge_pkg::cpu_state_e state,
  input  logic                   read_q,
  input  logic                   write_q,
  input  bridge_pkg::addr_t      addr_in,
  input  bridge_pkg::data_t      data_in,
  input  bridge_pkg::data_t      ext_cpu_index,
  input  logic                   ext_next_cpu_q,
  input  logic                   ext_bus_busy,
  input  bridge_pkg::cpu_msg_e   ext_cpu_msg_in,
  output logic                   rst,
  output logic                   ext_rst_e,
  output logic                   disp_online,
  output logic                   next_state,
  output bridge_pkg::addr_t      base_addr,
  output bridge_pkg::addr_t      base_addr_data,
  output logic                   ext_next_cpu_e,
  output logic                   ext_dispatcher_q,
  output bridge_pkg::cpu_msg_e   ext_cpu_msg,
  output logic                   ext_read_q,
  output logic                   ext_write_q,
  output bridge_pkg::data_t      cpu_index
);

  // sequencer to arbiter, reset announcement
  logic reset_msg;

  index_if idx ();

  // own ring index is visible to the core side
  assign cpu_index = idx.own_index;

  reset_sequencer reset_sequencer_inst (
    .clk       (clk),
    .ext_rst_b (ext_rst_b),
    .state     (state),
    .seq       (idx.sequencer),
    .rst       (rst),
    .ext_rst_e (ext_rst_e),
    .reset_msg (reset_msg)
  );

  cpu_index_tracker cpu_index_tracker_inst (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .state          (state),
    .ext_cpu_index  (ext_cpu_index),
    .ext_cpu_msg_in (ext_cpu_msg_in),
    .trk            (idx.tracker)
  );

  ring_arbiter ring_arbiter_inst (
    .clk              (clk),
    .ext_rst_b        (ext_rst_b),
    .state            (state),
    .read_q           (read_q),
    .write_q          (write_q),
    .addr_in          (addr_in),
    .data_in          (data_in),
    .ext_next_cpu_q   (ext_next_cpu_q),
    .ext_bus_busy     (ext_bus_busy),
    .reset_msg        (reset_msg),
    .arb              (idx.arbiter),
    .disp_online      (disp_online),
    .next_state       (next_state),
    .ext_next_cpu_e   (ext_next_cpu_e),
    .ext_dispatcher_q (ext_dispatcher_q),
    .ext_cpu_msg      (ext_cpu_msg),
    .base_addr        (base_addr),
    .base_addr_data   (base_addr_data),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q)
  );

endmodule

`default_nettype wire

/* verification/tb_cpu_bus_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_bus_bridge;
  import bridge_pkg::*;

  // tests take about 350 cycles together
  localparam int MAX_CYCLES     = 2000;
  localparam int GATE_CYCLES    = 200;
  localparam int RENUMBER_STEPS = 40;

  // states that exercise gating without touching the thread flow
  localparam cpu_state_e GATE_STATES [17] = '{
    READ_COND, READ_COND_P, READ_SRC1, READ_SRC1_P, READ_SRC0, READ_SRC0_P, READ_DST,
    START_READ_CMD, START_READ_CMD_P, WRITE_REG_IP, WRITE_DST, WRITE_DST_P,
    WRITE_SRC1, WRITE_SRC0, WRITE_COND, ALU_BEGIN, IDLE
  };

  logic       clk;
  logic       ext_rst_b;
  cpu_state_e state;
  logic       read_q;
  logic       write_q;
  addr_t      addr_in;
  data_t      data_in;
  data_t      ext_cpu_index;
  logic       ext_next_cpu_q;
  logic       ext_bus_busy;
  cpu_msg_e   ext_cpu_msg_in;
  logic       rst;
  logic       ext_rst_e;
  logic       disp_online;
  logic       next_state;
  addr_t      base_addr;
  addr_t      base_addr_data;
  logic       ext_next_cpu_e;
  logic       ext_dispatcher_q;
  cpu_msg_e   ext_cpu_msg;
  logic       ext_read_q;
  logic       ext_write_q;
  data_t      cpu_index;

  int          errors;
  int          errors_before;
  int          tests_run;
  int          tests_failed;
  int          cycle_count;
  logic [31:0] rng;
  // arms the freeze check only in the bus busy test
  logic        busy_watch;

  cpu_bus_bridge cpu_bus_bridge_inst (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("run did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // operand reads and command fetch
  function automatic logic in_read_group(input cpu_state_e s);
    return s inside {READ_COND, READ_COND_P, READ_SRC1, READ_SRC1_P, READ_SRC0,
                     READ_SRC0_P, READ_DST, START_READ_CMD, START_READ_CMD_P};
  endfunction

  function automatic logic in_write_group(input cpu_state_e s);
    return s inside {WRITE_REG_IP, WRITE_DST, WRITE_DST_P, WRITE_SRC1, WRITE_SRC0,
                     WRITE_COND};
  endfunction

  // renumbering rules, one clock of the index register
  function automatic data_t expected_index(input data_t own, input data_t other,
                                           input cpu_msg_e msg, input cpu_state_e s);
    data_t nxt;
    nxt = own;
    if (s == START_BEGIN) begin
      nxt[CPU_ACTIVE_BIT] = 1'b1;
    end else if (other != own) begin
      if (other[CPU_ACTIVE_BIT]) begin
        if (msg == MSG_END && own[CPU_ACTIVE_BIT] &&
            other[CPU_ACTIVE_BIT-1:0] < own[CPU_ACTIVE_BIT-1:0]) begin
          nxt[CPU_ACTIVE_BIT-1:0] = own[CPU_ACTIVE_BIT-1:0] - 1'b1;
        end
      end else if (msg == MSG_START) begin
        if (own[CPU_ACTIVE_BIT]) begin
          nxt[CPU_ACTIVE_BIT-1:0] = own[CPU_ACTIVE_BIT-1:0] + 1'b1;
        end else begin
          nxt[CPU_ACTIVE_BIT-1:0] = own[CPU_ACTIVE_BIT-1:0] - 1'b1;
        end
      end
    end
    return nxt;
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("%s (at %0t)", msg, $time);
  endtask

  // inputs change 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
    end
    errors_before = errors;
  endtask

  task automatic wait_next_state(input int limit, output logic seen);
    seen = 1'b0;
    for (int i = 0; i < limit && !seen; i++) begin
      next_cycle();
      seen = next_state;
    end
    if (!seen) begin
      report_problem($sformatf("next_state never pulsed within %0d cycles", limit));
    end
  endtask

  // grant in WAIT_FOR_START, then let the token go
  task automatic start_thread(input addr_t a, input data_t d);
    logic  seen;
    addr_t want_data;
    want_data = (d == '0) ? a + THREAD_HEADER_SPACE : d + THREAD_HEADER_SPACE;
    state          = WAIT_FOR_START;
    addr_in        = a;
    data_in        = d;
    ext_cpu_index  = cpu_index;
    ext_next_cpu_q = 1'b1;
    wait_next_state(4, seen);
    if (seen) begin
      assert (ext_cpu_msg == MSG_START) else report_mismatch("no MSG_START on grant");
      assert (disp_online && ext_next_cpu_e) else report_mismatch("grant did not take the bus");
      assert (base_addr == a + THREAD_HEADER_SPACE)
        else report_mismatch($sformatf("base_addr %h for addr_in %h", base_addr, a));
      assert (base_addr_data == want_data)
        else report_mismatch($sformatf("base_addr_data %h, expected %h", base_addr_data,
                                       want_data));
    end
    ext_next_cpu_q = 1'b0;
    state          = IDLE;
    next_cycle();
    assert (!next_state && ext_cpu_msg == MSG_NONE) else report_mismatch("start pulse too long");
    // no request pending, so the token moves on
    assert (!disp_online && !ext_next_cpu_e) else report_mismatch("token not handed on");
  endtask

  a_read_gate : assert property (
    @(posedge clk) disable iff (ext_rst_b)
    ext_read_q == (read_q && disp_online && in_read_group(state))
  ) else report_mismatch("ext_read_q breaks the gating rule");

  a_write_gate : assert property (
    @(posedge clk) disable iff (ext_rst_b)
    ext_write_q == (write_q && disp_online && in_write_group(state))
  ) else report_mismatch("ext_write_q breaks the gating rule");

  a_ext_rst_with_rst : assert property (
    @(posedge clk) disable iff (ext_rst_b)
    ext_rst_e |-> rst
  ) else report_mismatch("ext_rst_e without rst");

  a_busy_freeze : assert property (
    @(posedge clk) disable iff (ext_rst_b)
    (busy_watch && ext_bus_busy) |=>
      ($stable(disp_online) && !next_state && ext_cpu_msg == MSG_NONE)
  ) else report_mismatch("arbiter moved while the bus was busy");

  initial begin
    logic [31:0] load_value;
    logic        seen;
    logic        rst_seen;
    logic        ext_seen;
    int          reset_msgs;
    int          first_disp;
    int          reads_open;
    int          writes_open;
    data_t       other;
    data_t       expected;
    errors = 0;
    errors_before = 0;
    tests_run = 0;
    tests_failed = 0;
    cycle_count = 0;
    rng = 32'h658c0534;
    busy_watch = 1'b0;
    ext_rst_b = 1'b1;
    state = IDLE;
    read_q = 1'b0;
    write_q = 1'b0;
    addr_in = '0;
    data_in = '0;
    ext_cpu_index = '0;
    ext_next_cpu_q = 1'b0;
    ext_bus_busy = 1'b0;
    ext_cpu_msg_in = MSG_NONE;
    repeat (3) @(posedge clk);
    #1;

    // reset sequence, inactive slot with a mid-range count
    rng = xorshift32(rng);
    load_value = {22'd0, rng[9:0]} + 32'd100;
    ext_cpu_index = load_value;
    ext_rst_b = 1'b0;
    reset_msgs = 0;
    first_disp = 0;
    for (int n = 1; n <= 8; n++) begin
      next_cycle();
      assert (rst == (n == 4)) else report_mismatch($sformatf("rst %0b in cycle %0d", rst, n));
      assert (ext_rst_e == (n == 4))
        else report_mismatch($sformatf("ext_rst_e %0b in cycle %0d", ext_rst_e, n));
      if (ext_cpu_msg == MSG_RESET) reset_msgs++;
      if (ext_dispatcher_q && first_disp == 0) first_disp = n;
    end
    assert (reset_msgs == 1) else report_mismatch($sformatf("%0d MSG_RESET seen", reset_msgs));
    assert (first_disp != 0 && first_disp <= 5) else report_mismatch("ext_dispatcher_q late");
    assert (cpu_index == load_value)
      else report_mismatch($sformatf("cpu_index %h, expected %h", cpu_index, load_value));
    finish_test("reset sequence");

    // zero data pointer, then a real one
    rng = xorshift32(rng);
    start_thread(rng, '0);
    rng = xorshift32(rng);
    start_thread(rng, xorshift32(rng) | 32'd1);
    finish_test("thread start");

    reads_open = 0;
    writes_open = 0;
    for (int i = 0; i < GATE_CYCLES; i++) begin
      rng = xorshift32(rng);
      state = GATE_STATES[rng[15:8] % 17];
      read_q = rng[0];
      write_q = rng[1];
      ext_next_cpu_q = rng[2];
      ext_cpu_index = cpu_index;
      #2;
      if (ext_read_q) reads_open++;
      if (ext_write_q) writes_open++;
      next_cycle();
    end
    read_q = 1'b0;
    write_q = 1'b0;
    ext_next_cpu_q = 1'b0;
    state = IDLE;
    if (reads_open == 0 || writes_open == 0) begin
      report_problem("gating never passed both a read and a write");
    end
    next_cycle();
    finish_test("request gating");

    // other counts close to ours, so both compare outcomes occur
    for (int i = 0; i < RENUMBER_STEPS; i++) begin
      rng = xorshift32(rng);
      other = {rng[31], cpu_index[30:0] + 31'(rng[2:0]) - 31'd3};
      if (other == cpu_index) other[0] = ~other[0];
      ext_cpu_index = other;
      ext_cpu_msg_in = cpu_msg_e'(rng[5:4]);
      // halfway through, join the active group
      state = (i == RENUMBER_STEPS / 2) ? START_BEGIN : IDLE;
      expected = expected_index(cpu_index, other, ext_cpu_msg_in, state);
      next_cycle();
      assert (cpu_index == expected)
        else report_mismatch($sformatf("cpu_index %h, expected %h", cpu_index, expected));
    end
    ext_cpu_msg_in = MSG_NONE;
    state = IDLE;
    finish_test("renumbering");

    state = FINISH_BEGIN;
    ext_cpu_index = cpu_index;
    ext_next_cpu_q = 1'b1;
    wait_next_state(4, seen);
    assert (!seen || ext_cpu_msg == MSG_END) else report_mismatch("no MSG_END on grant");
    ext_next_cpu_q = 1'b0;
    state = FINISH_END;
    reset_msgs = 0;
    ext_seen = 1'b0;
    rst_seen = 1'b0;
    for (int n = 0; n < 10 && !rst_seen; n++) begin
      next_cycle();
      if (ext_cpu_msg == MSG_RESET) reset_msgs++;
      if (ext_rst_e) ext_seen = 1'b1;
      rst_seen = rst;
    end
    // core reset brings the core back to idle
    state = IDLE;
    if (!rst_seen) report_problem("rst did not pulse after the thread ended");
    assert (!ext_seen) else report_mismatch("ext_rst_e raised after a thread end");
    assert (reset_msgs == 0) else report_mismatch("index reloaded after a thread end");
    assert (cpu_index == '0) else report_mismatch($sformatf("cpu_index %h not cleared", cpu_index));
    finish_test("thread end");

    repeat (3) next_cycle();
    ext_bus_busy = 1'b1;
    busy_watch = 1'b1;
    state = WAIT_FOR_START;
    ext_cpu_index = cpu_index;
    ext_next_cpu_q = 1'b1;
    repeat (4) begin
      next_cycle();
      assert (!disp_online && !next_state && ext_cpu_msg == MSG_NONE)
        else report_mismatch("grant taken while the bus was busy");
    end
    // same grant goes through once the bus is free
    ext_bus_busy = 1'b0;
    busy_watch = 1'b0;
    wait_next_state(4, seen);
    assert (!seen || ext_cpu_msg == MSG_START) else report_mismatch("no MSG_START after busy");
    ext_next_cpu_q = 1'b0;
    state = IDLE;
    next_cycle();
    finish_test("bus busy");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cpu_bus_bridge.f */
source/bridge_pkg.sv
source/index_if.sv
source/reset_sequencer.sv
source/cpu_index_tracker.sv
source/ring_arbiter.sv
source/cpu_bus_bridge.sv
verification/tb_cpu_bus_bridge.sv

/* Makefile */
TOP = tb_cpu_bus_bridge
RTL = source/bridge_pkg.sv source/index_if.sv source/reset_sequencer.sv \
      source/cpu_index_tracker.sv source/ring_arbiter.sv source/cpu_bus_bridge.sv

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f cpu_bus_bridge.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Errors found" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "No errors" sim.log || { echo "simulation ended without a result"; exit 1; }

lint:
	verilator --lint-only -Wall --timescale 1ns/10ps --top-module cpu_bus_bridge $(RTL)

clean:
	rm -rf obj_dir sim.log
